// File: src/pixel_engine_cfg.svh
//####################################################################
// pixel engine configuration
// screen, object and palette sizes plus the APB address map
//####################################################################

`ifndef PIXEL_ENGINE_CFG_SVH
`define PIXEL_ENGINE_CFG_SVH

// screen coordinates
`define COORD_W         10

// palette and object table
`define NUM_PALETTE     8
`define NUM_OBJECTS     16

// object geometry in pixels
`define WALL_SIZE       32
`define BULLET_RADIUS   4

// APB bus
`define APB_ADDR_W      8
`define APB_DATA_W      32

// byte addresses of entry 0 of each table
`define PALETTE_BASE    8'h00
`define OBJECT_BASE     8'h40

`endif

// File: src/pixel_engine_pkg.sv
//####################################################################
// pixel engine types
// register layouts, text cell fields and colour formats
//####################################################################

`include "pixel_engine_cfg.svh"

package pixel_engine_pkg;

    typedef logic [`COORD_W-1:0] coord_t;
    typedef logic [2:0] pal_idx_t;

    // 4 bits per channel as stored in the palette
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb444_t;

    typedef struct packed {
        logic [3:0] rsvd_b;
        rgb444_t    colour_b;
        logic [3:0] rsvd_a;
        rgb444_t    colour_a;
    } palette_entry_t;

    typedef enum logic {
        KIND_WALL   = 1'b0,
        KIND_BULLET = 1'b1
    } object_kind_t;

    typedef struct packed {
        logic [6:0]   reserved;  // reads back zero
        pal_idx_t     pal_idx;   // walls only, colour A
        coord_t       y;
        coord_t       x;
        object_kind_t kind;
        logic         valid;
    } object_entry_t;

    // all zero means no text on this cell
    typedef struct packed {
        logic       invert;
        logic [6:0] reserved;
        pal_idx_t   fg_idx;
        logic       fg_sel;
        pal_idx_t   bg_idx;
        logic       bg_sel;
    } text_cell_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    // nibble repeated, so 0xf maps to full scale
    function automatic rgb_t widen(rgb444_t c);
        rgb_t w;
        w.red   = {c.red, c.red};
        w.green = {c.green, c.green};
        w.blue  = {c.blue, c.blue};
        return w;
    endfunction

endpackage

// File: src/sprite_regs.sv
//####################################################################
// sprite register file
// APB slave holding the colour palette and the object table
// zero wait states, out of range accesses flag pslverr
//####################################################################

`timescale 1ns/1ns
`include "pixel_engine_cfg.svh"

module sprite_regs (
    input  logic                                                pixel_clk,
    input  logic                                                reset,
    input  logic                                                psel,
    input  logic                                                penable,
    input  logic                                                pwrite,
    input  logic [`APB_ADDR_W-1:0]                              paddr,
    input  logic [`APB_DATA_W-1:0]                              pwdata,
    output logic [`APB_DATA_W-1:0]                              prdata,
    output logic                                                pready,
    output logic                                                pslverr,
    output pixel_engine_pkg::palette_entry_t [`NUM_PALETTE-1:0] palette,
    output pixel_engine_pkg::object_entry_t  [`NUM_OBJECTS-1:0] object_table
);

    localparam int AW     = `APB_ADDR_W;
    localparam int PAL_AW = $clog2(`NUM_PALETTE);
    localparam int OBJ_AW = $clog2(`NUM_OBJECTS);

    localparam logic [AW-1:0] PAL_BASE = AW'(`PALETTE_BASE);
    localparam logic [AW-1:0] OBJ_BASE = AW'(`OBJECT_BASE);
    localparam logic [AW-1:0] PAL_SPAN = AW'(`NUM_PALETTE * 4);
    localparam logic [AW-1:0] OBJ_SPAN = AW'(`NUM_OBJECTS * 4);

    logic [AW-1:0]     pal_off;
    logic [AW-1:0]     obj_off;
    logic              pal_sel;
    logic              obj_sel;
    logic [PAL_AW-1:0] pal_idx;
    logic [OBJ_AW-1:0] obj_idx;
    logic              wr_en;

    pixel_engine_pkg::object_entry_t obj_wdata;

    // below-base addresses wrap to a large offset and miss the table
    assign pal_off = paddr - PAL_BASE;
    assign obj_off = paddr - OBJ_BASE;
    assign pal_sel = pal_off < PAL_SPAN;
    assign obj_sel = obj_off < OBJ_SPAN;
    assign pal_idx = pal_off[PAL_AW+1:2];  // word index
    assign obj_idx = obj_off[OBJ_AW+1:2];

    assign wr_en = psel && penable && pwrite;

    always_comb begin
        obj_wdata = pixel_engine_pkg::object_entry_t'(pwdata);
        obj_wdata.reserved = '0;
    end

    always_ff @(posedge pixel_clk) begin
        if (reset) begin
            palette      <= '0;
            object_table <= '0;
        end else if (wr_en) begin
            if (pal_sel) begin
                palette[pal_idx] <= pixel_engine_pkg::palette_entry_t'(pwdata);
            end else if (obj_sel) begin
                object_table[obj_idx] <= obj_wdata;
            end
        end
    end

    // read data valid through setup and access phases
    always_comb begin
        prdata = '0;
        if (psel && !pwrite) begin
            if (pal_sel) begin
                prdata = palette[pal_idx];
            end else if (obj_sel) begin
                prdata = object_table[obj_idx];
            end
        end
    end

    assign pready  = 1'b1;
    assign pslverr = psel && penable && !(pal_sel || obj_sel);

endmodule

// File: src/object_hit.sv
//####################################################################
// object coverage test
// checks one wall block or bullet disc against the current pixel
// two register stages, offsets first, then the hit flag
//####################################################################

`timescale 1ns/1ns
`include "pixel_engine_cfg.svh"

module object_hit (
    input  logic                            pixel_clk,
    input  logic                            reset,
    input  pixel_engine_pkg::object_entry_t entry,
    input  pixel_engine_pkg::coord_t        draw_x,
    input  pixel_engine_pkg::coord_t        draw_y,
    output logic                            hit,
    output logic                            is_bullet,
    output pixel_engine_pkg::pal_idx_t      pal_idx
);

    localparam int CW     = `COORD_W;
    localparam int PROD_W = 2 * CW + 2;
    localparam int SQ_W   = PROD_W + 1;

    localparam logic [CW-1:0]   WALL_EDGE = CW'(`WALL_SIZE);
    localparam logic [SQ_W-1:0] RADIUS_SQ = SQ_W'(`BULLET_RADIUS * `BULLET_RADIUS);

    logic signed [CW:0]       dx;  // pixel minus object position
    logic signed [CW:0]       dy;
    logic                     s_valid;
    logic                     s_bullet;
    pixel_engine_pkg::pal_idx_t s_pal;

    logic signed [PROD_W-1:0] dx_sq;
    logic signed [PROD_W-1:0] dy_sq;
    logic [SQ_W-1:0]          dist_sq;
    logic                     wall_cover;
    logic                     bullet_cover;

    always_ff @(posedge pixel_clk) begin
        if (reset) begin
            s_valid <= 1'b0;
        end else begin
            s_valid <= entry.valid;
        end
    end

    always_ff @(posedge pixel_clk) begin
        dx       <= $signed({1'b0, draw_x}) - $signed({1'b0, entry.x});
        dy       <= $signed({1'b0, draw_y}) - $signed({1'b0, entry.y});
        s_bullet <= entry.kind == pixel_engine_pkg::KIND_BULLET;
        s_pal    <= entry.pal_idx;
    end

    always_comb begin
        dx_sq   = PROD_W'(dx) * PROD_W'(dx);
        dy_sq   = PROD_W'(dy) * PROD_W'(dy);
        dist_sq = {1'b0, dx_sq} + {1'b0, dy_sq};  // both squares non-negative

        // corner inclusive, far edge exclusive
        wall_cover = !dx[CW] && !dy[CW] &&
                     (dx[CW-1:0] < WALL_EDGE) && (dy[CW-1:0] < WALL_EDGE);
        bullet_cover = dist_sq <= RADIUS_SQ;
    end

    always_ff @(posedge pixel_clk) begin
        if (reset) begin
            hit       <= 1'b0;
            is_bullet <= 1'b0;
            pal_idx   <= '0;
        end else begin
            hit       <= s_valid && (s_bullet ? bullet_cover : wall_cover);
            is_bullet <= s_bullet;
            pal_idx   <= s_pal;
        end
    end

endmodule

// File: src/layer_compositor.sv
//####################################################################
// layer compositor
// text over objects over brick background, black while blanking
// text and brick decode in stage one, layer choice in stage two
//####################################################################

`timescale 1ns/1ns
`include "pixel_engine_cfg.svh"

module layer_compositor (
    input  logic                                                pixel_clk,
    input  logic                                                reset,
    input  logic [`NUM_OBJECTS-1:0]                             hit,
    input  logic [`NUM_OBJECTS-1:0]                             is_bullet,
    input  pixel_engine_pkg::pal_idx_t [`NUM_OBJECTS-1:0]       pal_idx,
    input  pixel_engine_pkg::palette_entry_t [`NUM_PALETTE-1:0] palette,
    input  pixel_engine_pkg::coord_t                            draw_x,
    input  pixel_engine_pkg::coord_t                            draw_y,
    input  logic                                                video_on,
    input  pixel_engine_pkg::text_cell_t                        char_code,
    input  logic [7:0]                                          font_row,
    output pixel_engine_pkg::rgb_t                              rgb
);

    localparam pixel_engine_pkg::rgb_t BULLET_RGB = 24'hff5500;
    localparam pixel_engine_pkg::rgb_t MORTAR_RGB = 24'h808080;
    localparam pixel_engine_pkg::rgb_t BRICK_RGB  = 24'ha03020;

    // stage one, the pixel as sampled
    logic                         s1_video_on;
    logic [4:0]                   s1_x_lo;
    logic [3:0]                   s1_y_lo;
    pixel_engine_pkg::text_cell_t s1_char;
    logic [7:0]                   s1_font;
    logic                         font_bit;
    logic                         mortar;

    // stage two, aligned with the object hits
    logic                         s2_video_on;
    logic                         s2_text_on;
    pixel_engine_pkg::pal_idx_t   s2_text_idx;
    logic                         s2_text_sel;
    pixel_engine_pkg::rgb_t       s2_bg_rgb;
    logic                         obj_on;
    logic                         obj_bullet;
    pixel_engine_pkg::pal_idx_t   obj_idx;
    pixel_engine_pkg::rgb_t       rgb_next;

    function automatic pixel_engine_pkg::rgb_t pick_colour(
        pixel_engine_pkg::palette_entry_t entry,
        logic                             sel
    );
        return pixel_engine_pkg::widen(sel ? entry.colour_b : entry.colour_a);
    endfunction

    always_ff @(posedge pixel_clk) begin
        if (reset) begin
            s1_video_on <= 1'b0;
        end else begin
            s1_video_on <= video_on;
        end
    end

    always_ff @(posedge pixel_clk) begin
        s1_x_lo <= draw_x[4:0];
        s1_y_lo <= draw_y[3:0];
        s1_char <= char_code;
        s1_font <= font_row;
    end

    // msb of the font row is the leftmost pixel
    assign font_bit = s1_font[3'd7 - s1_x_lo[2:0]] ^ s1_char.invert;
    assign mortar   = (s1_x_lo == '0) || (s1_y_lo == '0);  // 32x16 bricks

    always_ff @(posedge pixel_clk) begin
        if (reset) begin
            s2_video_on <= 1'b0;
            s2_text_on  <= 1'b0;
        end else begin
            s2_video_on <= s1_video_on;
            s2_text_on  <= s1_char != '0;
        end
    end

    always_ff @(posedge pixel_clk) begin
        s2_text_idx <= font_bit ? s1_char.fg_idx : s1_char.bg_idx;
        s2_text_sel <= font_bit ? s1_char.fg_sel : s1_char.bg_sel;
        s2_bg_rgb   <= mortar ? MORTAR_RGB : BRICK_RGB;
    end

    // walk down so the lowest slot wins
    always_comb begin
        obj_on     = 1'b0;
        obj_bullet = 1'b0;
        obj_idx    = '0;
        for (int i = `NUM_OBJECTS - 1; i >= 0; i--) begin
            if (hit[i]) begin
                obj_on     = 1'b1;
                obj_bullet = is_bullet[i];
                obj_idx    = pal_idx[i];
            end
        end
    end

    always_comb begin
        if (!s2_video_on) begin
            rgb_next = '0;
        end else if (s2_text_on) begin
            rgb_next = pick_colour(palette[s2_text_idx], s2_text_sel);
        end else if (obj_on) begin
            rgb_next = obj_bullet ? BULLET_RGB : pick_colour(palette[obj_idx], 1'b0);
        end else begin
            rgb_next = s2_bg_rgb;
        end
    end

    always_ff @(posedge pixel_clk) begin
        if (reset) begin
            rgb <= '0;
        end else begin
            rgb <= rgb_next;
        end
    end

endmodule

// File: src/pixel_engine.sv
//####################################################################
// pixel engine
// colour stage of the tank game drawing engine
// APB registers, one tester per object slot and the compositor
// rgb follows the sampled pixel by two clocks
//####################################################################

`timescale 1ns/1ns
`include "pixel_engine_cfg.svh"

module pixel_engine (
    input  logic                         pixel_clk,
    input  logic                         reset,
    input  pixel_engine_pkg::coord_t     draw_x,
    input  pixel_engine_pkg::coord_t     draw_y,
    input  logic                         video_on,
    input  pixel_engine_pkg::text_cell_t char_code,
    input  logic [7:0]                   font_row,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [`APB_ADDR_W-1:0]       paddr,
    input  logic [`APB_DATA_W-1:0]       pwdata,
    output logic [`APB_DATA_W-1:0]       prdata,
    output logic                         pready,
    output logic                         pslverr,
    output pixel_engine_pkg::rgb_t       rgb
);

    pixel_engine_pkg::palette_entry_t [`NUM_PALETTE-1:0] palette;
    pixel_engine_pkg::object_entry_t  [`NUM_OBJECTS-1:0] object_table;
    logic [`NUM_OBJECTS-1:0]                             hit;
    logic [`NUM_OBJECTS-1:0]                             is_bullet;
    pixel_engine_pkg::pal_idx_t [`NUM_OBJECTS-1:0]       pal_idx;

    sprite_regs u_regs (
        .pixel_clk    (pixel_clk),
        .reset        (reset),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .palette      (palette),
        .object_table (object_table)
    );

    for (genvar i = 0; i < `NUM_OBJECTS; i++) begin : g_obj
        object_hit u_hit (
            .pixel_clk (pixel_clk),
            .reset     (reset),
            .entry     (object_table[i]),
            .draw_x    (draw_x),
            .draw_y    (draw_y),
            .hit       (hit[i]),
            .is_bullet (is_bullet[i]),
            .pal_idx   (pal_idx[i])
        );
    end

    layer_compositor u_comp (
        .pixel_clk (pixel_clk),
        .reset     (reset),
        .hit       (hit),
        .is_bullet (is_bullet),
        .pal_idx   (pal_idx),
        .palette   (palette),
        .draw_x    (draw_x),
        .draw_y    (draw_y),
        .video_on  (video_on),
        .char_code (char_code),
        .font_row  (font_row),
        .rgb       (rgb)
    );

endmodule

// File: verification/pixel_engine_properties.sv
//####################################################################
// pixel engine properties
// APB handshake and blanking checks, bound to the top level
//####################################################################

`timescale 1ns/1ns

module pixel_engine_properties (
    input logic        pixel_clk,
    input logic        reset,
    input logic        psel,
    input logic        pready,
    input logic        pslverr,
    input logic        video_on,
    input logic [23:0] rgb
);

    int failures = 0;

    // zero wait states
    pready_high: assert property (@(posedge pixel_clk) disable iff (reset) pready)
        else begin failures++; $error("pready went low"); end

    pslverr_needs_psel: assert property (
        @(posedge pixel_clk) disable iff (reset) pslverr |-> psel
    ) else begin failures++; $error("pslverr set without psel"); end

    // a blanked pixel leaves the pipe black
    // rgb registered two edges on, seen in the sample of the edge after
    blank_is_black: assert property (
        @(posedge pixel_clk) disable iff (reset) !video_on |-> ##3 (rgb == 24'h0)
    ) else begin failures++; $error("rgb not black two clocks after blanking"); end

endmodule

// File: verification/pixel_engine_tb.sv
//####################################################################
// pixel engine testbench
// replays register accesses and pixel vectors from the test data
// file, rgb compared two clocks after each sampled pixel
//####################################################################

`timescale 1ns/1ns

module pixel_engine_tb;

    logic                         pixel_clk;
    logic                         reset;
    pixel_engine_pkg::coord_t     draw_x;
    pixel_engine_pkg::coord_t     draw_y;
    logic                         video_on;
    pixel_engine_pkg::text_cell_t char_code;
    logic [7:0]                   font_row;
    logic                         psel;
    logic                         penable;
    logic                         pwrite;
    logic [7:0]                   paddr;
    logic [31:0]                  pwdata;
    logic [31:0]                  prdata;
    logic                         pready;
    logic                         pslverr;
    pixel_engine_pkg::rgb_t       rgb;

    string       lines[$];
    string       test_name;
    int          cycle_count;
    int          cycle_limit;
    int          test_count;
    int          check_count;
    int          error_count;
    int          test_checks;
    int          test_errors;
    logic [2:0]  pipe_valid;  // stage 2 is due at the next edge
    logic [23:0] pipe_rgb [3];

    pixel_engine DUT (
        .pixel_clk (pixel_clk),
        .reset     (reset),
        .draw_x    (draw_x),
        .draw_y    (draw_y),
        .video_on  (video_on),
        .char_code (char_code),
        .font_row  (font_row),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .rgb       (rgb)
    );

    bind pixel_engine pixel_engine_properties u_props (
        .pixel_clk (pixel_clk),
        .reset     (reset),
        .psel      (psel),
        .pready    (pready),
        .pslverr   (pslverr),
        .video_on  (video_on),
        .rgb       (rgb)
    );

    initial begin
        pixel_clk = 1'b0;
        forever #5 pixel_clk = ~pixel_clk;
    end

    // one clock, then compare the pixel that is now two clocks past sampling
    task automatic step_cycle();
        @(posedge pixel_clk);
        #1;
        if (pipe_valid[2]) begin
            test_checks++;
            if (rgb !== pipe_rgb[2]) begin
                $display("CHECK FAILED at %0t ns: rgb expected %06h, got %06h",
                         $time, pipe_rgb[2], rgb);
                test_errors++;
            end
        end
        pipe_valid  = {pipe_valid[1:0], 1'b0};
        pipe_rgb[2] = pipe_rgb[1];
        pipe_rgb[1] = pipe_rgb[0];
    endtask

    task automatic drain_pipeline();
        while (pipe_valid != 3'b000) begin
            step_cycle();
        end
    endtask

    task automatic apb_transfer(input logic write, input logic [7:0] addr,
                                input logic [31:0] data, output logic [31:0] rdata,
                                output logic err);
        int waits;
        waits   = 0;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        step_cycle();
        penable = 1'b1;
        #3;
        while (!pready && waits < 16) begin
            step_cycle();
            #3;
            waits++;
        end
        if (!pready) begin
            $display("APB transfer to address %02h never completed, pready stayed low", addr);
            test_errors++;
        end
        rdata = prdata;
        err   = pslverr;
        step_cycle();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic finish_test();
        if (test_checks > 0 || test_errors > 0) begin
            $display("test %s: %0d checks, %0d errors, %s", test_name, test_checks,
                     test_errors, (test_errors == 0) ? "passed" : "failed");
            test_count++;
            check_count += test_checks;
            error_count += test_errors;
        end
        test_checks = 0;
        test_errors = 0;
    endtask

    initial begin
        int          fd;
        string       line;
        string       args;
        logic [31:0] f [6];
        logic [31:0] rdata;
        logic        rerr;

        reset     = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        draw_x    = '0;
        draw_y    = '0;
        video_on  = 1'b0;
        char_code = '0;
        font_row  = '0;
        pipe_valid  = '0;
        test_count  = 0;
        check_count = 0;
        error_count = 0;
        test_checks = 0;
        test_errors = 0;
        test_name   = "setup";

        fd = $fopen("verification/pixel_engine_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/pixel_engine_testdata.txt");
            test_errors++;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) > 0) lines.push_back(line);
            end
            $fclose(fd);
        end
        cycle_limit = lines.size() * 4 + 100;

        repeat (4) @(posedge pixel_clk);
        #1;
        reset = 1'b0;

        foreach (lines[i]) begin
            line = lines[i];
            if (line.len() < 2 || line[0] == "#") continue;
            args = line.substr(2, line.len() - 1);
            if (line[0] == "T") begin
                drain_pipeline();
                finish_test();
                test_name = line.substr(2, line.len() - 2);  // drop the newline
            end else if (line[0] == "W" && $sscanf(args, "%h %h", f[0], f[1]) == 2) begin
                drain_pipeline();
                apb_transfer(1'b1, f[0][7:0], f[1], rdata, rerr);
            end else if (line[0] == "R" &&
                         $sscanf(args, "%h %h %h", f[0], f[1], f[2]) == 3) begin
                drain_pipeline();
                apb_transfer(1'b0, f[0][7:0], 32'h0, rdata, rerr);
                test_checks += 2;
                if (rdata !== f[1]) begin
                    $display("CHECK FAILED at %0t ns: prdata expected %08h, got %08h",
                             $time, f[1], rdata);
                    test_errors++;
                end
                if (rerr !== f[2][0]) begin
                    $display("CHECK FAILED at %0t ns: pslverr expected %0b, got %0b",
                             $time, f[2][0], rerr);
                    test_errors++;
                end
            end else if (line[0] == "P" && $sscanf(args, "%d %d %h %h %h %h",
                         f[0], f[1], f[2], f[3], f[4], f[5]) == 6) begin
                draw_x        = f[0][9:0];
                draw_y        = f[1][9:0];
                video_on      = f[2][0];
                char_code     = f[3][15:0];
                font_row      = f[4][7:0];
                pipe_valid[0] = 1'b1;
                pipe_rgb[0]   = f[5][23:0];
                step_cycle();
            end else begin
                $display("test data line %0d could not be read: %s", i + 1, line);
                test_errors++;
            end
        end

        drain_pipeline();
        if (DUT.u_props.failures != 0) begin
            $display("%0d assertion failures in the bound properties", DUT.u_props.failures);
            test_errors += DUT.u_props.failures;
        end
        finish_test();
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0 && test_count > 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // run limit scales with the number of data lines
    initial begin
        cycle_count = 0;
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge pixel_clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the test data did not finish", cycle_count);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: build.f
+incdir+src
src/pixel_engine_pkg.sv
src/sprite_regs.sv
src/object_hit.sv
src/layer_compositor.sv
src/pixel_engine.sv
verification/pixel_engine_properties.sv
verification/pixel_engine_tb.sv

// File: Makefile
# Verilator build and run of the pixel engine testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check $(LOG)"
	@echo "make clean  remove the build directory and $(LOG)"
	@echo "make help   list these targets"

test:
	verilator --binary --assert -f build.f --top-module pixel_engine_tb -Mdir obj_dir
	./obj_dir/Vpixel_engine_tb +verilator+error+limit+100 | tee $(LOG)
	@grep -q "^RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: verification/pixel_engine_testdata.txt
# W addr data | R addr data err | P x y video char font rgb | T test name
# x and y decimal, all other fields hex
T register_access
W 00 04560123
W 04 0f0000f0
W 08 0fff000f
W 0c 03210a5c
W 40 fe420101
R 04 0f0000f0 0
R 0c 03210a5c 0
R 40 00420101 0
R 7c 00000000 0
W 24 12345678
R 24 00000000 1
R 80 00000000 1
T background
P 0 0 1 0000 00 808080
P 32 5 1 0000 00 808080
P 5 16 1 0000 00 808080
P 5 5 1 0000 00 a03020
P 33 17 1 0000 00 a03020
P 5 5 0 0000 00 000000
T walls
W 44 008c8320
P 64 32 1 0000 00 00ff00
P 95 63 1 0000 00 00ff00
P 96 41 1 0000 00 808080
P 70 31 1 0000 00 a03020
P 210 210 1 0000 00 a03020
T bullets_priority
W 48 000644b3
P 300 100 1 0000 00 ff5500
P 304 100 1 0000 00 ff5500
P 296 100 1 0000 00 ff5500
P 302 103 1 0000 00 ff5500
P 305 100 1 0000 00 a03020
P 303 103 1 0000 00 a03020
W 4c 00c5a489
W 50 00078503
P 300 100 1 0000 00 ff5500
P 305 100 1 0000 00 aa55cc
P 320 120 1 0000 00 aa55cc
P 324 120 1 0000 00 ff5500
T text
P 8 0 1 0034 81 ff0000
P 9 0 1 0034 81 0000ff
P 15 0 1 0034 81 ff0000
P 8 0 1 8034 81 0000ff
P 9 0 1 8034 81 ff0000
P 4 0 1 0061 0f aa55cc
P 3 0 1 0061 0f 445566
P 64 32 1 0034 ff ff0000
P 300 100 1 0034 00 0000ff
T streaming
P 63 40 1 0000 00 a03020
P 64 40 1 0000 00 00ff00
P 70 40 0 0000 00 000000
P 96 40 1 0000 00 808080
W 04 0f000abc
P 64 40 1 0000 00 aabbcc
P 63 40 1 0000 00 a03020
R 04 0f000abc 0
